// ==== tb/nand_golden.txt ====
# opcode uart_en resp0 resp1 err data0_expected data1_expected (all hex)
# err 0 none, 1 unsupported opcode, 2 extra CMD write while busy
70 0 c0 00 0 c0 00
90 0 2c da 0 2c da
ff 0 00 00 0 2c da
70 1 e0 00 0 e0 da
90 1 98 d3 0 98 d3
ff 1 00 00 0 98 d3
55 0 00 00 1 98 d3
00 1 00 00 1 98 d3
70 0 c1 00 2 c1 d3
90 1 ec f1 2 ec f1
ff 0 00 00 2 ec f1
70 1 80 00 0 80 f1

// ==== nand_probe_top.f ====
source/nand_pkg.sv
source/probe_regs_pkg.sv
source/nand_op_if.sv
source/nand_apb_regs.sv
source/nand_cmd_seq.sv
source/uart_tx.sv
source/nand_probe_top.sv
tb/nand_probe_asserts.sv
tb/tb_nand_probe.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the NAND probe testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_nand_probe \
    -f nand_probe_top.f --Mdir obj_dir -o tb_nand_probe > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_nand_probe > sim.log 2>&1
cat sim.log

grep -qF "*** TEST PASSED ***" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== tb/tb_nand_probe.sv ====
/* testbench for the NAND flash probe
   runs golden-file commands over APB against a NAND chip model and a UART receiver */

`timescale 1ns/1ps

module tb_nand_probe;
    import nand_pkg::*;
    import probe_regs_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int MAX_TESTS = 32;
    localparam int FRAME_CYCLES = UART_FRAME_BITS * UART_DIV;
    // read ID with two frames of back-pressure plus the serial tail and APB traffic
    localparam int OP_CYCLES = 8 * PHASE_CYCLES + 3 * FRAME_CYCLES + 64;
    localparam int POLL_LIMIT = 200;

    logic                  CLK;
    logic                  arst_n;
    logic [APB_ADDR_W-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_DATA_W-1:0] pwdata;
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  nand_ce_n;
    logic                  nand_cle;
    logic                  nand_ale;
    logic                  nand_we_n;
    logic                  nand_re_n;
    logic [7:0]            nand_dout;
    logic                  nand_oe;
    logic [7:0]            nand_din = 8'h00;
    logic                  uart_txd;

    // golden columns, one entry per test line
    logic [7:0] g_op   [MAX_TESTS];
    logic [7:0] g_uart [MAX_TESTS];
    logic [7:0] g_r0   [MAX_TESTS];
    logic [7:0] g_r1   [MAX_TESTS];
    logic [7:0] g_err  [MAX_TESTS];
    logic [7:0] g_d0   [MAX_TESTS];
    logic [7:0] g_d1   [MAX_TESTS];
    int         n_tests;
    logic       loaded;

    // NAND model state, counters only ever grow
    logic [7:0] resp [2];
    logic [7:0] last_cmd;
    logic [7:0] last_addr;
    int         cmd_count;
    int         addr_count;
    int         re_count;
    int         rd_idx;

    logic [7:0] rx_q [$];
    logic [7:0] rx_shift;
    int         frame_errors;
    int         checks;
    int         value_errors;
    int         other_errors;

    nand_probe_top DUT (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .paddr     (paddr),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .nand_ce_n (nand_ce_n),
        .nand_cle  (nand_cle),
        .nand_ale  (nand_ale),
        .nand_we_n (nand_we_n),
        .nand_re_n (nand_re_n),
        .nand_dout (nand_dout),
        .nand_oe   (nand_oe),
        .nand_din  (nand_din),
        .uart_txd  (uart_txd)
    );

    bind nand_cmd_seq nand_probe_asserts u_asserts (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .nand_cle  (nand_cle),
        .nand_ale  (nand_ale),
        .nand_we_n (nand_we_n),
        .nand_re_n (nand_re_n),
        .nand_oe   (nand_oe),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            value_errors++;
            $display("FAILED at %0t: %s = 0x%0h, expected 0x%0h", $time, name, actual, expected);
        end
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
        @(negedge CLK);
        psel    = 1'b1;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        penable = 1'b0;
        @(negedge CLK);
        penable = 1'b1;
        #1;
        err = pslverr;
        check_value("pready", pready, 1);
        @(negedge CLK);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        @(negedge CLK);
        psel    = 1'b1;
        pwrite  = 1'b0;
        paddr   = addr;
        penable = 1'b0;
        @(negedge CLK);
        penable = 1'b1;
        #1;
        data = prdata;
        check_value("pready", pready, 1);
        @(negedge CLK);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // bytes returned per opcode: one status byte, two ID bytes, none for reset
    function automatic int expected_reads(input logic [7:0] op);
        case (op)
            8'h70:   expected_reads = 1;
            8'h90:   expected_reads = 2;
            default: expected_reads = 0;
        endcase
    endfunction

    task automatic load_golden();
        int    fd;
        int    fields;
        string line;
        fd = $fopen("tb/nand_golden.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("ERROR: the golden file tb/nand_golden.txt could not be opened");
            return;
        end
        while (!$feof(fd) && n_tests < MAX_TESTS) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin
                fields = $sscanf(line, "%h %h %h %h %h %h %h", g_op[n_tests], g_uart[n_tests],
                                 g_r0[n_tests], g_r1[n_tests], g_err[n_tests],
                                 g_d0[n_tests], g_d1[n_tests]);
                if (fields == 7) begin
                    n_tests++;
                end else begin
                    other_errors++;
                    $display("ERROR: a golden line has %0d fields instead of 7", fields);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic wait_done(output logic [31:0] status);
        int polls;
        polls  = 0;
        status = '0;
        while (!status[STATUS_DONE] && polls < POLL_LIMIT) begin
            apb_read(REG_STATUS, status);
            polls++;
        end
        if (!status[STATUS_DONE]) begin
            other_errors++;
            $display("ERROR at %0t: the operation never reported done", $time);
        end
    endtask

    // n of zero waits out one whole frame so a stray frame would still show up
    task automatic wait_rx(input int base, input int n);
        int cycles;
        cycles = 0;
        while ((n == 0 || rx_q.size() - base < n) && cycles < FRAME_CYCLES + UART_DIV) begin
            @(negedge CLK);
            cycles++;
        end
    endtask

    task automatic run_test(input int t);
        logic        err;
        logic [31:0] rdata;
        logic [31:0] ctrl_val;
        int          n_reads;
        int          cmd_base;
        int          addr_base;
        int          re_base;
        int          rx_base;
        n_reads   = expected_reads(g_op[t]);
        resp[0]   = g_r0[t];
        resp[1]   = g_r1[t];
        cmd_base  = cmd_count;
        addr_base = addr_count;
        re_base   = re_count;
        rx_base   = rx_q.size();
        ctrl_val  = '0;
        ctrl_val[CTRL_UART_EN] = g_uart[t][0];
        apb_write(REG_CTRL, ctrl_val, err);
        check_value("CTRL pslverr", err, 0);
        apb_write(REG_CMD, {24'h0, g_op[t]}, err);
        check_value("CMD pslverr", err, g_err[t] == 8'h01);
        if (g_err[t] == 8'h02) begin
            apb_write(REG_CMD, {24'h0, OP_READ_STATUS}, err);
            check_value("CMD pslverr while busy", err, 1);
        end
        if (g_err[t] != 8'h01) begin
            apb_read(REG_STATUS, rdata);
            check_value("STATUS while busy", rdata, 32'(1) << STATUS_BUSY);
            wait_done(rdata);
            check_value("STATUS after done", rdata, 32'(1) << STATUS_DONE);
        end else begin
            apb_read(REG_STATUS, rdata);
            check_value("STATUS busy", rdata[STATUS_BUSY], 0);
        end
        wait_rx(rx_base, g_uart[t][0] ? n_reads : 0);
        check_value("command cycles", cmd_count - cmd_base, g_err[t] == 8'h01 ? 0 : 1);
        if (g_err[t] != 8'h01) begin
            check_value("latched command", last_cmd, g_op[t]);
        end
        check_value("address cycles", addr_count - addr_base, g_op[t] == OP_READ_ID);
        if (g_op[t] == OP_READ_ID) begin
            check_value("address byte", last_addr, 8'h00);
        end
        check_value("read strobes", re_count - re_base, n_reads);
        apb_read(REG_DATA0, rdata);
        check_value("DATA0", rdata, {24'h0, g_d0[t]});
        apb_read(REG_DATA1, rdata);
        check_value("DATA1", rdata, {24'h0, g_d1[t]});
        check_value("UART byte count", rx_q.size() - rx_base, g_uart[t][0] ? n_reads : 0);
        if (g_uart[t][0] && rx_q.size() - rx_base == n_reads) begin
            for (int i = 0; i < n_reads; i++) begin
                check_value("UART byte", rx_q[rx_base + i], resp[i]);
            end
        end
    endtask

    // NAND chip model, command and address latch on the rising WE edge
    always @(posedge nand_we_n) begin
        if (nand_cle) begin
            cmd_count++;
            last_cmd = nand_dout;
            rd_idx   = 0;
        end else if (nand_ale) begin
            addr_count++;
            last_addr = nand_dout;
        end
    end

    // data stays on the bus from the falling RE edge until the next read
    always @(negedge nand_re_n) begin
        nand_din = (rd_idx < 2) ? resp[rd_idx] : 8'h00;
        rd_idx++;
        re_count++;
    end

    // UART receiver samples in the middle of each bit
    always begin
        @(negedge uart_txd);
        repeat (UART_DIV / 2) @(negedge CLK);
        if (uart_txd !== 1'b0) begin
            frame_errors++;
            $display("ERROR at %0t: UART start bit did not hold low", $time);
        end else begin
            for (int i = 0; i < 8; i++) begin
                repeat (UART_DIV) @(negedge CLK);
                rx_shift[i] = uart_txd;
            end
            repeat (UART_DIV) @(negedge CLK);
            if (uart_txd !== 1'b1) begin
                frame_errors++;
                $display("ERROR at %0t: UART stop bit was not high", $time);
            end
            rx_q.push_back(rx_shift);
        end
    end

    initial begin
        wait (loaded);
        repeat (n_tests * OP_CYCLES * 2 + 200) @(posedge CLK);
        $display("ERROR at %0t: watchdog expired before the tests finished", $time);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        logic [31:0] rdata;
        int          total;
        arst_n  = 1'b0;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        loaded  = 1'b0;
        load_golden();
        loaded = 1'b1;
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        arst_n = 1'b1;
        @(negedge CLK);
        check_value("nand_ce_n", nand_ce_n, 1);
        check_value("nand_we_n", nand_we_n, 1);
        check_value("nand_re_n", nand_re_n, 1);
        check_value("nand_cle", nand_cle, 0);
        check_value("nand_ale", nand_ale, 0);
        check_value("nand_oe", nand_oe, 0);
        check_value("uart_txd", uart_txd, 1);
        apb_read(REG_STATUS, rdata);
        check_value("STATUS after reset", rdata, 0);
        for (int t = 0; t < n_tests; t++) begin
            run_test(t);
        end
        total = value_errors + other_errors + frame_errors;
        $display("checks %0d, value errors %0d, other errors %0d, UART frame errors %0d",
                 checks, value_errors, other_errors, frame_errors);
        if (total == 0 && n_tests > 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// ==== tb/nand_probe_asserts.sv ====
/* NAND pin protocol assertions, bound to the command sequencer */

`timescale 1ns/1ps

module nand_probe_asserts (
    input logic       CLK,
    input logic       arst_n,
    input logic       nand_cle,
    input logic       nand_ale,
    input logic       nand_we_n,
    input logic       nand_re_n,
    input logic       nand_oe,
    input logic [7:0] tx_data,
    input logic       tx_valid,
    input logic       tx_ready
);
    import nand_pkg::*;

    cle_ale_exclusive: assert property (
        @(posedge CLK) disable iff (!arst_n) !(nand_cle && nand_ale)
    ) else $error("CLE and ALE are high together");

    we_re_exclusive: assert property (
        @(posedge CLK) disable iff (!arst_n) !(!nand_we_n && !nand_re_n)
    ) else $error("WE and RE are low together");

    // the chip drives the bus while RE is low
    re_bus_released: assert property (
        @(posedge CLK) disable iff (!arst_n) !nand_re_n |-> !nand_oe
    ) else $error("bus driven while RE is low");

    // a byte offered to the transmitter stays put until it is taken
    handoff_held: assert property (
        @(posedge CLK) disable iff (!arst_n)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_data)
    ) else $error("hand-off byte dropped or changed before it was accepted");

    we_pulse_width: assert property (
        @(posedge CLK) disable iff (!arst_n) $fell(nand_we_n) |-> ##PHASE_CYCLES $rose(nand_we_n)
    ) else $error("WE pulse length differs from the phase length");

endmodule

// ==== source/nand_probe_top.sv ====
/* NAND flash probe top level
   joins the APB registers, pin sequencer and UART transmitter */

`timescale 1ns/1ps

module nand_probe_top (
    input  logic                                CLK,
    input  logic                                arst_n,
    input  logic [probe_regs_pkg::APB_ADDR_W-1:0] paddr,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [probe_regs_pkg::APB_DATA_W-1:0] pwdata,
    output logic [probe_regs_pkg::APB_DATA_W-1:0] prdata,
    output logic                                pready,
    output logic                                pslverr,
    output logic                                nand_ce_n,
    output logic                                nand_cle,
    output logic                                nand_ale,
    output logic                                nand_we_n,
    output logic                                nand_re_n,
    output logic [7:0]                          nand_dout,
    output logic                                nand_oe,
    input  logic [7:0]                          nand_din,
    output logic                                uart_txd
);

    logic [7:0] tx_data;
    logic       tx_valid;
    logic       tx_ready;

    nand_op_if op_bus ();

    nand_apb_regs u_regs (
        .CLK     (CLK),
        .arst_n  (arst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .op      (op_bus.host)
    );

    nand_cmd_seq u_seq (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .op        (op_bus.seq),
        .nand_ce_n (nand_ce_n),
        .nand_cle  (nand_cle),
        .nand_ale  (nand_ale),
        .nand_we_n (nand_we_n),
        .nand_re_n (nand_re_n),
        .nand_oe   (nand_oe),
        .nand_dout (nand_dout),
        .nand_din  (nand_din),
        .tx_data   (tx_data),
        .tx_valid  (tx_valid),
        .tx_ready  (tx_ready)
    );

    uart_tx u_uart (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .uart_txd (uart_txd)
    );

endmodule

// ==== source/uart_tx.sv ====
/* 8N1 serial transmitter
   takes one byte on a valid/ready hand-off and shifts it out LSB first */

`timescale 1ns/1ps

module uart_tx (
    input  logic       CLK,
    input  logic       arst_n,
    input  logic [7:0] tx_data,
    input  logic       tx_valid,
    output logic       tx_ready,
    output logic       uart_txd
);
    import probe_regs_pkg::*;

    logic                       active;
    logic [UART_FRAME_BITS-1:0] shift_q;
    logic [BAUD_W-1:0]          baud_cnt;
    logic [FRAME_CNT_W-1:0]     bit_cnt;
    logic                       baud_tick;

    assign baud_tick = (baud_cnt == BAUD_W'(UART_DIV - 1));
    assign tx_ready  = !active;
    assign uart_txd  = shift_q[0];

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            active   <= 1'b0;
            shift_q  <= '1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (!active) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            if (tx_valid) begin
                active  <= 1'b1;
                // stop bit, data, start bit
                shift_q <= {1'b1, tx_data, 1'b0};
            end
        end else if (baud_tick) begin
            baud_cnt <= '0;
            // ones shift in behind the frame so the line rests high
            shift_q  <= {1'b1, shift_q[UART_FRAME_BITS-1:1]};
            if (bit_cnt == FRAME_CNT_W'(UART_FRAME_BITS - 1)) begin
                active  <= 1'b0;
                bit_cnt <= '0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

endmodule

// ==== source/nand_cmd_seq.sv ====
/* NAND command sequencer
   steps the control pins through command, address and read phases and captures data */

`timescale 1ns/1ps

module nand_cmd_seq (
    input  logic       CLK,
    input  logic       arst_n,
    nand_op_if.seq     op,
    output logic       nand_ce_n,
    output logic       nand_cle,
    output logic       nand_ale,
    output logic       nand_we_n,
    output logic       nand_re_n,
    output logic       nand_oe,
    output logic [7:0] nand_dout,
    input  logic [7:0] nand_din,
    output logic [7:0] tx_data,
    output logic       tx_valid,
    input  logic       tx_ready
);
    import nand_pkg::*;

    seq_state_e            state_q;
    seq_state_e            state_d;
    logic [PHASE_W-1:0]    phase_cnt;
    logic                  phase_last;
    logic [READ_CNT_W-1:0] byte_cnt;
    logic [READ_CNT_W-1:0] byte_total;
    logic                  more_bytes;
    logic                  capture;
    logic [7:0]            rbyte_q;
    logic                  rbyte_valid_q;
    logic [INDEX_W-1:0]    rbyte_index_q;
    logic                  ce_n_d;
    logic                  cle_d;
    logic                  ale_d;
    logic                  we_n_d;
    logic                  re_n_d;
    logic                  oe_d;
    logic [7:0]            dout_d;

    assign phase_last = (phase_cnt == PHASE_W'(PHASE_CYCLES - 1));
    assign byte_total = read_count(op.opcode);
    assign more_bytes = (byte_cnt < byte_total);
    assign capture    = (state_q == READ_RE) && phase_last;

    assign op.busy        = (state_q != IDLE);
    assign op.done        = (state_q == FINISH);
    assign op.rbyte       = rbyte_q;
    assign op.rbyte_valid = rbyte_valid_q;
    assign op.rbyte_index = rbyte_index_q;
    assign tx_data        = rbyte_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:       if (op.start) state_d = CMD_SETUP;
            CMD_SETUP:  if (phase_last) state_d = CMD_WE;
            CMD_WE: begin
                if (phase_last) begin
                    if (op.opcode == OP_READ_ID) begin
                        state_d = ADDR_SETUP;
                    end else if (more_bytes) begin
                        state_d = READ_RE;
                    end else begin
                        state_d = FINISH;
                    end
                end
            end
            ADDR_SETUP: if (phase_last) state_d = ADDR_WE;
            ADDR_WE:    if (phase_last) state_d = READ_RE;
            READ_RE:    if (phase_last) state_d = READ_HOLD;
            READ_HOLD: begin
                if (phase_last) begin
                    if (op.uart_en) begin
                        state_d = HANDOFF;
                    end else begin
                        state_d = more_bytes ? READ_RE : FINISH;
                    end
                end
            end
            // CE stays low while the transmitter is still busy with a frame
            HANDOFF:    if (tx_valid && tx_ready) state_d = more_bytes ? READ_RE : FINISH;
            FINISH:     state_d = IDLE;
            default:    state_d = IDLE;
        endcase
    end

    // pin levels for the state being entered, so the registered pins line up with state_q
    always_comb begin
        ce_n_d = 1'b0;
        cle_d  = 1'b0;
        ale_d  = 1'b0;
        we_n_d = 1'b1;
        re_n_d = 1'b1;
        oe_d   = 1'b0;
        dout_d = 8'hFF;
        case (state_d)
            CMD_SETUP: begin
                cle_d  = 1'b1;
                we_n_d = 1'b0;
                oe_d   = 1'b1;
                dout_d = op.opcode;
            end
            // WE returns high with CLE still set, the chip latches on this edge
            CMD_WE: begin
                cle_d  = 1'b1;
                oe_d   = 1'b1;
                dout_d = op.opcode;
            end
            ADDR_SETUP: begin
                ale_d  = 1'b1;
                we_n_d = 1'b0;
                oe_d   = 1'b1;
                dout_d = 8'h00;
            end
            ADDR_WE: begin
                ale_d  = 1'b1;
                oe_d   = 1'b1;
                dout_d = 8'h00;
            end
            READ_RE:              re_n_d = 1'b0;
            READ_HOLD, HANDOFF:   ce_n_d = 1'b0;
            default:              ce_n_d = 1'b1;
        endcase
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            state_q       <= IDLE;
            phase_cnt     <= '0;
            byte_cnt      <= '0;
            rbyte_valid_q <= 1'b0;
            rbyte_index_q <= '0;
            nand_ce_n     <= 1'b1;
            nand_cle      <= 1'b0;
            nand_ale      <= 1'b0;
            nand_we_n     <= 1'b1;
            nand_re_n     <= 1'b1;
            nand_oe       <= 1'b0;
            nand_dout     <= 8'hFF;
            tx_valid      <= 1'b0;
        end else begin
            state_q       <= state_d;
            phase_cnt     <= (state_d != state_q) ? '0 : phase_cnt + 1'b1;
            rbyte_valid_q <= capture;
            if (op.start && state_q == IDLE) begin
                byte_cnt <= '0;
            end else if (capture) begin
                byte_cnt      <= byte_cnt + 1'b1;
                rbyte_index_q <= byte_cnt[INDEX_W-1:0];
            end
            nand_ce_n <= ce_n_d;
            nand_cle  <= cle_d;
            nand_ale  <= ale_d;
            nand_we_n <= we_n_d;
            nand_re_n <= re_n_d;
            nand_oe   <= oe_d;
            nand_dout <= dout_d;
            tx_valid  <= (state_d == HANDOFF);
        end
    end

    // sampled just before RE rises again
    always_ff @(posedge CLK) begin
        if (capture) begin
            rbyte_q <= nand_din;
        end
    end

endmodule

// ==== source/nand_apb_regs.sv ====
/* APB3 register block of the NAND probe
   accepts commands, holds the UART enable and collects the bytes read back */

`timescale 1ns/1ps

module nand_apb_regs (
    input  logic                                CLK,
    input  logic                                arst_n,
    input  logic [probe_regs_pkg::APB_ADDR_W-1:0] paddr,
    input  logic                                psel,
    input  logic                                penable,
    input  logic                                pwrite,
    input  logic [probe_regs_pkg::APB_DATA_W-1:0] pwdata,
    output logic [probe_regs_pkg::APB_DATA_W-1:0] prdata,
    output logic                                pready,
    output logic                                pslverr,
    nand_op_if.host                             op
);
    import nand_pkg::*;
    import probe_regs_pkg::*;

    logic         access;
    logic         wr_cmd;
    logic         wr_ctrl;
    logic         cmd_ok;
    logic         start_q;
    nand_opcode_e opcode_q;
    logic         uart_en_q;
    logic         ctrl_uart_en;
    logic         done_flag;
    logic [7:0]   data0;
    logic [7:0]   data1;

    function automatic logic is_supported(logic [7:0] code);
        case (code)
            OP_RESET, OP_READ_STATUS, OP_READ_ID: is_supported = 1'b1;
            default:                              is_supported = 1'b0;
        endcase
    endfunction

    assign access  = psel && penable;
    assign wr_cmd  = access && pwrite && (paddr == REG_CMD);
    assign wr_ctrl = access && pwrite && (paddr == REG_CTRL);

    // a start still in flight counts as busy, busy follows it by one cycle
    assign cmd_ok  = is_supported(pwdata[7:0]) && !op.busy && !start_q;

    assign pready  = 1'b1;
    assign pslverr = wr_cmd && !cmd_ok;

    assign op.start   = start_q;
    assign op.opcode  = opcode_q;
    assign op.uart_en = uart_en_q;

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            start_q      <= 1'b0;
            opcode_q     <= OP_RESET;
            uart_en_q    <= 1'b0;
            ctrl_uart_en <= 1'b0;
            done_flag    <= 1'b0;
            data0        <= '0;
            data1        <= '0;
        end else begin
            start_q <= wr_cmd && cmd_ok;
            if (wr_cmd && cmd_ok) begin
                opcode_q  <= nand_opcode_e'(pwdata[7:0]);
                uart_en_q <= ctrl_uart_en;
            end
            if (wr_ctrl) begin
                ctrl_uart_en <= pwdata[CTRL_UART_EN];
            end
            if (op.done) begin
                done_flag <= 1'b1;
            end else if (wr_cmd && cmd_ok) begin
                done_flag <= 1'b0;
            end
            if (op.rbyte_valid) begin
                if (op.rbyte_index == '0) begin
                    data0 <= op.rbyte;
                end else begin
                    data1 <= op.rbyte;
                end
            end
        end
    end

    always_comb begin
        prdata = '0;
        case (paddr)
            REG_CMD:    prdata[7:0] = opcode_q;
            REG_CTRL:   prdata[CTRL_UART_EN] = ctrl_uart_en;
            REG_STATUS: begin
                prdata[STATUS_BUSY] = op.busy;
                prdata[STATUS_DONE] = done_flag;
            end
            REG_DATA0:  prdata[7:0] = data0;
            REG_DATA1:  prdata[7:0] = data1;
            default:    prdata = '0;
        endcase
    end

endmodule

// ==== source/nand_op_if.sv ====
/* operation request and result bus between the register block and the NAND sequencer */

`timescale 1ns/1ps

interface nand_op_if;
    import nand_pkg::*;

    logic               start;
    nand_opcode_e       opcode;
    logic               uart_en;
    logic               busy;
    logic               done;
    logic [7:0]         rbyte;
    logic               rbyte_valid;
    logic [INDEX_W-1:0] rbyte_index;

    // start is only issued while busy is low
    modport host (
        output start, opcode, uart_en,
        input  busy, done, rbyte, rbyte_valid, rbyte_index
    );

    modport seq (
        input  start, opcode, uart_en,
        output busy, done, rbyte, rbyte_valid, rbyte_index
    );

endinterface

// ==== source/probe_regs_pkg.sv ====
/* probe register map
   APB addresses, control and status bit positions, UART timing */

package probe_regs_pkg;

    localparam int APB_ADDR_W = 8;
    localparam int APB_DATA_W = 32;

    typedef enum logic [APB_ADDR_W-1:0] {
        REG_CMD    = 8'h00,
        REG_CTRL   = 8'h04,
        REG_STATUS = 8'h08,
        REG_DATA0  = 8'h0C,
        REG_DATA1  = 8'h10
    } reg_addr_e;

    localparam int CTRL_UART_EN = 0;

    localparam int STATUS_BUSY = 0;
    localparam int STATUS_DONE = 1;

    // clocks per serial bit, frame is start + 8 data + stop
    localparam int UART_DIV = 16;
    localparam int BAUD_W = $clog2(UART_DIV);
    localparam int UART_FRAME_BITS = 10;
    localparam int FRAME_CNT_W = $clog2(UART_FRAME_BITS);

endpackage

// ==== source/nand_pkg.sv ====
/* NAND probe command definitions
   opcodes, sequencer states and pin phase timing shared by the RTL and testbench */

package nand_pkg;

    // clock cycles spent in every pin phase of the sequencer
    localparam int PHASE_CYCLES = 4;
    localparam int PHASE_W = $clog2(PHASE_CYCLES);

    // read ID returns manufacturer and device bytes
    localparam int ID_BYTES = 2;
    localparam int INDEX_W = $clog2(ID_BYTES);
    localparam int READ_CNT_W = $clog2(ID_BYTES + 1);

    typedef enum logic [7:0] {
        OP_RESET       = 8'hFF,
        OP_READ_STATUS = 8'h70,
        OP_READ_ID     = 8'h90
    } nand_opcode_e;

    typedef enum logic [3:0] {
        IDLE,
        CMD_SETUP,
        CMD_WE,
        ADDR_SETUP,
        ADDR_WE,
        READ_RE,
        READ_HOLD,
        HANDOFF,
        FINISH
    } seq_state_e;

    // number of data bytes each operation reads back
    function automatic logic [READ_CNT_W-1:0] read_count(nand_opcode_e op);
        case (op)
            OP_READ_STATUS: read_count = READ_CNT_W'(1);
            OP_READ_ID:     read_count = READ_CNT_W'(ID_BYTES);
            default:        read_count = '0;
        endcase
    endfunction

endpackage
